//--- verilog/cpuPkg.sv
package cpuPkg;

	// Datapath widths
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;
	localparam int regCount = 8;
	localparam int opcodeWidth = 4;
	localparam int aluOpWidth = 3;
	localparam int flagWidth = 4;
	localparam int brKindWidth = 2;

	typedef logic [dataWidth-1:0] dataWord;
	typedef logic [dataWidth-1:0] instrWord;
	typedef logic [regAddrWidth-1:0] regAddr;
	typedef logic [opcodeWidth-1:0] opcode;
	typedef logic [aluOpWidth-1:0] aluOp;
	typedef logic [flagWidth-1:0] flagBits;
	typedef logic [brKindWidth-1:0] brKind;

	// Bit positions inside NZCV
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

	// Major opcodes, instruction bits 15..12
	localparam opcode opAdd = 4'h0;
	localparam opcode opSub = 4'h1;
	localparam opcode opAnd = 4'h2;
	localparam opcode opOrr = 4'h3;
	localparam opcode opEor = 4'h4;
	localparam opcode opLsl = 4'h5;
	localparam opcode opLsr = 4'h6;
	localparam opcode opMovi = 4'h7;
	localparam opcode opAddi = 4'h8;
	localparam opcode opLdr = 4'h9;
	localparam opcode opStr = 4'ha;
	localparam opcode opCmp = 4'hb;
	localparam opcode opB = 4'hc;
	localparam opcode opBeq = 4'hd;
	localparam opcode opBne = 4'he;
	localparam opcode opNop = 4'hf;

	// ALU operations
	localparam aluOp aluAdd = 3'd0;
	localparam aluOp aluSub = 3'd1;
	localparam aluOp aluAnd = 3'd2;
	localparam aluOp aluOrr = 3'd3;
	localparam aluOp aluEor = 3'd4;
	localparam aluOp aluLsl = 3'd5;
	localparam aluOp aluLsr = 3'd6;
	localparam aluOp aluPassB = 3'd7;

	// Branch classes
	localparam brKind brNone = 2'd0;
	localparam brKind brAlways = 2'd1;
	localparam brKind brEq = 2'd2;
	localparam brKind brNe = 2'd3;

endpackage

//--- verilog/regFile.sv
`timescale 1ns/1ps
module regFile (
	input logic clk,
	input logic arstN,
	input logic writeEnable,
	input cpuPkg::regAddr writeAddr,
	input cpuPkg::dataWord writeData,
	input cpuPkg::regAddr readAddrA,
	input cpuPkg::regAddr readAddrB,
	output cpuPkg::dataWord readDataA,
	output cpuPkg::dataWord readDataB
);
	import cpuPkg::*;

	// Eight general purpose registers, no hardwired zero
	dataWord regs [regCount];

	// Write at the clock edge, all registers clear on reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Port A
	// a write to the same register this cycle is passed straight through
	always_comb begin
		if (writeEnable && (writeAddr == readAddrA)) begin
			readDataA = writeData;
		end else begin
			readDataA = regs[readAddrA];
		end
	end

	// Port B, same write-through rule
	always_comb begin
		if (writeEnable && (writeAddr == readAddrB)) begin
			readDataB = writeData;
		end else begin
			readDataB = regs[readAddrB];
		end
	end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
module alu (
	input cpuPkg::dataWord a,
	input cpuPkg::dataWord b,
	input cpuPkg::aluOp op,
	output cpuPkg::dataWord result,
	output cpuPkg::flagBits flags
);
	import cpuPkg::*;

	// Shared adder, subtract is a + ~b + 1
	dataWord addB;
	logic carryIn;
	logic [dataWidth:0] sum;
	logic overflow;
	// Shift distance from low bits of b
	logic [3:0] shiftAmt;
	logic isArith;

	assign carryIn = (op == aluSub);
	assign addB = carryIn ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, addB} + {{dataWidth{1'b0}}, carryIn};

	// Signed overflow: operands agree in sign, result does not
	assign overflow = (a[dataWidth-1] == addB[dataWidth-1]) &&
		(sum[dataWidth-1] != a[dataWidth-1]);

	assign shiftAmt = b[3:0];
	assign isArith = (op == aluAdd) || (op == aluSub);

	// Result select
	always_comb begin
		case (op)
			aluAdd: result = sum[dataWidth-1:0];
			aluSub: result = sum[dataWidth-1:0];
			aluAnd: result = a & b;
			aluOrr: result = a | b;
			aluEor: result = a ^ b;
			aluLsl: result = a << shiftAmt;
			aluLsr: result = a >> shiftAmt;
			default: result = b;
		endcase
	end

	// N and Z from the result
	assign flags[flagN] = result[dataWidth-1];
	assign flags[flagZ] = (result == '0);
	// Carry out for add, inverted borrow for subtract
	assign flags[flagC] = isArith & sum[dataWidth];
	// V only meaningful for add and subtract
	assign flags[flagV] = isArith & overflow;

endmodule

//--- verilog/cpuControl.sv
`timescale 1ns/1ps
module cpuControl (
	input cpuPkg::instrWord instr,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg,
	output logic useImm,
	output cpuPkg::dataWord imm,
	output cpuPkg::aluOp aluSel,
	output logic setFlags,
	output cpuPkg::brKind branch,
	output cpuPkg::regAddr readAddrA,
	output cpuPkg::regAddr readAddrB,
	output cpuPkg::regAddr writeAddr
);
	import cpuPkg::*;

	opcode opField;
	regAddr rdField;
	regAddr raField;
	regAddr rbField;

	// Instruction fields
	assign opField = instr[15:12];
	assign rdField = instr[11:9];
	assign raField = instr[8:6];
	assign rbField = instr[5:3];

	// Register addresses
	assign readAddrA = raField;
	// STR needs the value of rd on port B
	assign readAddrB = (opField == opStr) ? rdField : rbField;
	assign writeAddr = rdField;

	// Immediate extraction, zero extended
	always_comb begin
		if (opField == opMovi) begin
			imm = {8'd0, instr[7:0]};
		end else begin
			imm = {10'd0, instr[5:0]};
		end
	end

	// Main decode
	always_comb begin
		// Defaults describe a NOP
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		useImm = 1'b0;
		aluSel = aluPassB;
		setFlags = 1'b0;
		branch = brNone;
		case (opField)
			opAdd: begin
				regWrite = 1'b1;
				aluSel = aluAdd;
				setFlags = 1'b1;
			end
			opSub: begin
				regWrite = 1'b1;
				aluSel = aluSub;
				setFlags = 1'b1;
			end
			opAnd: begin
				regWrite = 1'b1;
				aluSel = aluAnd;
				setFlags = 1'b1;
			end
			opOrr: begin
				regWrite = 1'b1;
				aluSel = aluOrr;
				setFlags = 1'b1;
			end
			opEor: begin
				regWrite = 1'b1;
				aluSel = aluEor;
				setFlags = 1'b1;
			end
			opLsl: begin
				regWrite = 1'b1;
				aluSel = aluLsl;
			end
			opLsr: begin
				regWrite = 1'b1;
				aluSel = aluLsr;
			end
			// Immediate goes through the ALU untouched
			opMovi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
			end
			opAddi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				aluSel = aluAdd;
				setFlags = 1'b1;
			end
			// Address is ra + imm6 for both memory forms
			opLdr: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				useImm = 1'b1;
				aluSel = aluAdd;
			end
			opStr: begin
				memWrite = 1'b1;
				useImm = 1'b1;
				aluSel = aluAdd;
			end
			// Flags only, no register result
			opCmp: begin
				aluSel = aluSub;
				setFlags = 1'b1;
			end
			opB: branch = brAlways;
			opBeq: branch = brEq;
			opBne: branch = brNe;
			default: ;
		endcase
	end

endmodule

//--- verilog/dataMem.sv
`timescale 1ns/1ps
module dataMem #(
	parameter int dataDepth = 256
) (
	input logic clk,
	input logic arstN,
	input logic writeEnable,
	input cpuPkg::dataWord addr,
	input cpuPkg::dataWord writeData,
	output cpuPkg::dataWord readData
);
	import cpuPkg::*;

	localparam int indexWidth = $clog2(dataDepth);

	dataWord mem [dataDepth];
	logic [indexWidth-1:0] index;

	// Upper address bits are ignored
	assign index = addr[indexWidth-1:0];

	// Combinational read
	assign readData = mem[index];

	// Clocked write, whole array clears on reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < dataDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEnable) begin
			mem[index] <= writeData;
		end
	end

endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ps
module cpu #(
	parameter int dataDepth = 256
) (
	input logic clk,
	input logic arstN,
	output cpuPkg::dataWord imemAddr,
	input cpuPkg::instrWord imemData,
	output logic wbValid,
	output cpuPkg::regAddr wbAddr,
	output cpuPkg::dataWord wbData
);
	import cpuPkg::*;

	// Fetch / decode stage
	dataWord pc;
	dataWord pcNext;
	logic regWrite, memWrite, memToReg, useImm, setFlags;
	dataWord imm;
	aluOp aluSel;
	brKind branch;
	regAddr readAddrA, readAddrB, writeAddr;
	dataWord readDataA, readDataB;

	// Execute stage
	logic validE;
	instrWord instrE;
	dataWord pcE, readDataAE, readDataBE, immE;
	logic regWriteE, memWriteE, memToRegE, useImmE, setFlagsE;
	aluOp aluSelE;
	brKind branchE;
	regAddr writeAddrE;
	dataWord aluB, aluResult, memReadData;
	flagBits aluFlags;
	flagBits flagsQ;
	dataWord brOffset, brTarget;
	logic taken;

	assign imemAddr = pc;

	// PC counts words; taken branch redirects from execute
	assign pcNext = taken ? brTarget : pc + 16'd1;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

	cpuControl control (
		.instr(imemData), .regWrite, .memWrite, .memToReg, .useImm, .imm, .aluSel,
		.setFlags, .branch, .readAddrA, .readAddrB, .writeAddr
	);

	// Write port driven from execute, reads from decode
	regFile registers (
		.clk, .arstN, .writeEnable(wbValid), .writeAddr(wbAddr), .writeData(wbData),
		.readAddrA, .readAddrB, .readDataA, .readDataB
	);

	// Slot valid bit, cleared when the slot behind a taken branch is flushed
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validE <= 1'b0;
		end else begin
			validE <= !taken;
		end
	end

	// Decode-to-execute payload
	always_ff @(posedge clk) begin
		instrE <= imemData;
		pcE <= pc;
		readDataAE <= readDataA;
		readDataBE <= readDataB;
		immE <= imm;
		regWriteE <= regWrite;
		memWriteE <= memWrite;
		memToRegE <= memToReg;
		useImmE <= useImm;
		setFlagsE <= setFlags;
		aluSelE <= aluSel;
		branchE <= branch;
		writeAddrE <= writeAddr;
	end

	// Operand B is the register or the decoded immediate
	assign aluB = useImmE ? immE : readDataBE;

	alu aluUnit (.a(readDataAE), .b(aluB), .op(aluSelE), .result(aluResult), .flags(aluFlags));

	// STR data comes from port B, which holds rd
	dataMem #(.dataDepth(dataDepth)) dataMemory (
		.clk, .arstN, .writeEnable(validE & memWriteE), .addr(aluResult),
		.writeData(readDataBE), .readData(memReadData)
	);

	// NZCV updated at the end of a valid flag-setting instruction
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flagsQ <= '0;
		end else if (validE && setFlagsE) begin
			flagsQ <= aluFlags;
		end
	end

	// B has a 12 bit offset, conditional forms 9 bits
	assign brOffset = (branchE == brAlways) ? {{4{instrE[11]}}, instrE[11:0]} :
		{{7{instrE[8]}}, instrE[8:0]};
	// Relative to the branch's own address
	assign brTarget = pcE + brOffset;

	// Only Z decides the conditional forms
	always_comb begin
		case (branchE)
			brAlways: taken = validE;
			brEq: taken = validE & flagsQ[flagZ];
			brNe: taken = validE & !flagsQ[flagZ];
			default: taken = 1'b0;
		endcase
	end

	// Write-back is the register file write port
	assign wbValid = validE & regWriteE;
	assign wbAddr = writeAddrE;
	assign wbData = memToRegE ? memReadData : aluResult;

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps
module clockGen #(
	parameter int halfPeriod = 5,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic arstN
);

	// Free running clock, 10 ns period
	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Reset falls just after time zero so every flop sees the falling edge
	initial begin
		arstN = 1'b1;
		#1;
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		// Release lands 1 ns after a rising edge
		#1;
		arstN = 1'b1;
	end

endmodule

//--- testbench/cpu_checker.sv
`timescale 1ns/1ps
module cpuChecker (
	input logic clk,
	input logic arstN,
	input cpuPkg::dataWord imemAddr,
	input logic wbValid,
	input logic taken
);

	// Failures so far, read by the testbench at the end of the run
	int failCount = 0;

	// No register write while reset is held
	resetQuiet: assert property (@(posedge clk) !arstN |-> !wbValid)
		else begin
			$error("write-back strobe high during reset");
			failCount++;
		end

	// Execute stage still holds a bubble in the first cycle out of reset
	firstCycleQuiet: assert property (@(posedge clk) $rose(arstN) |-> !wbValid)
		else begin
			$error("write-back strobe high in the first cycle after reset");
			failCount++;
		end

	// Fetch walks forward one word at a time
	fetchSequential: assert property (@(posedge clk) disable iff (!arstN)
		!taken |=> imemAddr == $past(imemAddr) + 16'd1)
		else begin
			$error("fetch address did not advance by one");
			failCount++;
		end

	// Slot behind a taken branch is a bubble
	flushQuiet: assert property (@(posedge clk) disable iff (!arstN) taken |=> !wbValid)
		else begin
			$error("flushed slot produced a write-back");
			failCount++;
		end

endmodule

bind cpu cpuChecker chk0 (
	.clk(clk),
	.arstN(arstN),
	.imemAddr(imemAddr),
	.wbValid(wbValid),
	.taken(taken)
);

//--- testbench/cpuTb.sv
`timescale 1ns/1ps
module cpuTb;
	import cpuPkg::*;

	localparam int dataDepth = 256;
	// Program space served on the fetch port
	localparam int progDepth = 64;
	localparam int progIndexWidth = $clog2(progDepth);
	localparam int resetTimeout = 20;
	localparam int runTimeout = 500;
	localparam int drainCycles = 8;
	localparam instrWord nopWord = {opNop, 12'h000};

	logic clk;
	logic arstN;
	dataWord imemAddr;
	instrWord imemData;
	logic wbValid;
	regAddr wbAddr;
	dataWord wbData;

	instrWord progMem [progDepth];
	logic progLoaded [progDepth];
	// Expected commits in order
	regAddr expAddr [$];
	dataWord expData [$];

	int mismatchCount;
	int otherCount;
	int commitCount;

	clockGen #(.resetCycles(2)) clocks (.clk, .arstN);

	cpu #(.dataDepth(dataDepth)) dut0 (
		.clk, .arstN, .imemAddr, .imemData, .wbValid, .wbAddr, .wbData
	);

	// Fetch is combinational, words never loaded read as NOP
	always_comb begin
		if ((imemAddr < progDepth) && progLoaded[imemAddr[progIndexWidth-1:0]]) begin
			imemData = progMem[imemAddr[progIndexWidth-1:0]];
		end else begin
			imemData = nopWord;
		end
	end

	task automatic checkValue(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	// P lines fill program memory, W lines queue the expected commits
	task automatic loadStimulus();
		int fd;
		int fields;
		string line;
		byte tag;
		logic [15:0] first;
		logic [15:0] second;
		for (int i = 0; i < progDepth; i++) begin
			progLoaded[i] = 1'b0;
		end
		fd = $fopen("testbench/cpu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/cpu_stimulus.txt for reading");
			otherCount++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%c %h %h", tag, first, second);
				if (fields == 3 && tag == "P") begin
					if (first < progDepth) begin
						progMem[first[progIndexWidth-1:0]] = second;
						progLoaded[first[progIndexWidth-1:0]] = 1'b1;
					end else begin
						$display("Program address %h lies outside the program space", first);
						otherCount++;
					end
				end else if (fields == 3 && tag == "W") begin
					expAddr.push_back(first[2:0]);
					expData.push_back(second);
				end
			end
			$fclose(fd);
		end
	endtask

	// Sampled mid-cycle, the write commits at the next rising edge
	always @(negedge clk) begin
		if (arstN === 1'b1 && wbValid === 1'b1) begin
			commitCount++;
			if (expAddr.size() == 0) begin
				$display("Write-back to r%0d with %h at %0t after the expected list ran out",
					wbAddr, wbData, $time);
				otherCount++;
			end else begin
				checkValue("wbAddr", 16'(wbAddr), 16'(expAddr.pop_front()));
				checkValue("wbData", wbData, expData.pop_front());
			end
		end
	end

	initial begin
		int cycles;
		int expectedTotal;
		int failTotal;
		mismatchCount = 0;
		otherCount = 0;
		commitCount = 0;
		loadStimulus();
		expectedTotal = expAddr.size();
		if (expectedTotal == 0) begin
			$display("The stimulus file gave no expected write-backs");
			otherCount++;
		end
		// Reset goes low first, then comes back high
		cycles = 0;
		while (arstN !== 1'b0 && cycles < resetTimeout) begin
			@(posedge clk);
			cycles++;
		end
		while (arstN !== 1'b1 && cycles < resetTimeout) begin
			@(posedge clk);
			cycles++;
		end
		if (arstN !== 1'b1) begin
			$display("Reset was not released within %0d cycles", resetTimeout);
			otherCount++;
		end else begin
			cycles = 0;
			while (expAddr.size() > 0 && cycles < runTimeout) begin
				@(posedge clk);
				cycles++;
			end
			if (expAddr.size() > 0) begin
				$display("Timed out after %0d cycles with %0d write-backs still missing",
					runTimeout, expAddr.size());
				otherCount++;
			end
			// Program ends in a branch to itself, extra commits show up here
			repeat (drainCycles) @(posedge clk);
		end
		failTotal = mismatchCount + otherCount + dut0.chk0.failCount;
		$display("errors: mismatches %0d, other %0d, assertions %0d, write-backs %0d of %0d",
			mismatchCount, otherCount, dut0.chk0.failCount, commitCount, expectedTotal);
		if (failTotal == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- testbench/cpu_stimulus.txt
# P <word address> <instruction>   program word, hex
# W <register> <value>             expected write-back in commit order, hex
P 00 7212  # movi r1, 0x12
P 01 0478  # add r2, r1, r7   r7 untouched since reset, r1 just written
P 02 76ff  # movi r3, 0xff
P 03 7a01  # movi r5, 1
P 04 7c0f  # movi r6, 15
P 05 58f8  # lsl r4, r3, r7   by 0
P 06 58e8  # lsl r4, r3, r5   by 1
P 07 58f0  # lsl r4, r3, r6   by 15
P 08 6930  # lsr r4, r4, r6   by 15
P 09 68e8  # lsr r4, r3, r5   by 1
P 0a 68f8  # lsr r4, r3, r7   by 0
P 0b 19e8  # sub r4, r7, r5   0 - 1
P 0c 0928  # add r4, r4, r5   wraps to 0
P 0d 24c8  # and r2, r3, r1
P 0e 3470  # orr r2, r1, r6
P 0f 4498  # eor r2, r2, r3
P 10 84bf  # addi r2, r2, 0x3f
P 11 a543  # str r2, [r5, #3]   address 4
P 12 91c4  # ldr r0, [r7, #4]
P 13 9149  # ldr r0, [r5, #9]   address 10, never written
P 14 c002  # b +2
P 15 72aa  # movi r1, 0xaa      skipped
P 16 b0d8  # cmp r3, r3
P 17 e002  # bne +2             not taken
P 18 d002  # beq +2             taken
P 19 72bb  # movi r1, 0xbb      skipped
P 1a 7203  # movi r1, 3
P 1b 1268  # sub r1, r1, r5     loop body
P 1c e1ff  # bne -1
P 1d 0050  # add r0, r1, r2
P 1e c000  # b 0                parks the core
W 1 0012
W 2 0012
W 3 00ff
W 5 0001
W 6 000f
W 4 00ff
W 4 01fe
W 4 8000
W 4 0001
W 4 007f
W 4 00ff
W 4 ffff
W 4 0000
W 2 0012
W 2 001f
W 2 00e0
W 2 011f
W 0 011f
W 0 0000
W 1 0003
W 1 0002
W 1 0001
W 1 0000
W 0 011f

//--- list.f
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/cpuControl.sv
verilog/dataMem.sv
verilog/cpu.sv
testbench/clockGen.sv
testbench/cpu_checker.sv
testbench/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - verilog/cpuPkg.sv
  - verilog/regFile.sv
  - verilog/alu.sv
  - verilog/cpuControl.sv
  - verilog/dataMem.sv
  - verilog/cpu.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/cpu_checker.sv
      - testbench/cpuTb.sv
